// File: data_convert.f
verilog/conv_pkg.sv
verilog/sensor_bcd.sv
verilog/msg_format.sv
verilog/msg_ctrl.sv
verilog/data_convert.sv
testbench/conv_checker.sv
testbench/conv_asserts.sv
testbench/tb_data_convert.sv

// File: run_sim.sh
#!/bin/sh
# build and run the data_convert testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f data_convert.f \
    --top-module tb_data_convert -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: testbench/conv_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module conv_asserts (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_full,
    input  logic             i_push,
    input  conv_pkg::char_t  i_char
);

    int unsigned fail_cnt = 0;  // read by the testbench

    full_blocks_push: assert property (@(posedge clk) disable iff (rst) i_full |=> !i_push)
        else begin
            $error("push issued in the cycle after full");
            fail_cnt++;
        end

    push_not_null: assert property (@(posedge clk) disable iff (rst) i_push |-> i_char != 8'h00)
        else begin
            $error("null character pushed");
            fail_cnt++;
        end

endmodule

bind data_convert conv_asserts i_asserts (
    .clk    (clk),
    .rst    (rst),
    .i_full (i_full),
    .i_push (o_push),
    .i_char (o_data)
);

`default_nettype wire

// File: testbench/conv_checker.sv
`timescale 1ns/10ps
`default_nettype none

module conv_checker (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_push,
    input  conv_pkg::char_t  i_data
);

    import conv_pkg::*;

    char_t       exp_q[$];      // bytes still to arrive, in order
    char_t       expected;
    int unsigned cyc      = 0;
    int unsigned arm_cnt  = 0;  // bumped by arm_latency
    int unsigned arm_seen = 0;
    int unsigned lat_due  = 0;
    int unsigned checks   = 0;
    int unsigned errors   = 0;

    // text from the stim file, bar stands for a newline
    task automatic add_expected(input string txt);
        int i;
        for (i = 0; i < txt.len(); i++) begin
            if (txt[i] == "|") begin
                exp_q.push_back(ASCII_NL);
            end else begin
                exp_q.push_back(char_t'(txt[i]));
            end
        end
    endtask

    // called at the falling edge before i_start is driven
    task automatic arm_latency();
        lat_due = cyc + 4;  // start sampled one edge later, push three edges on
        arm_cnt = arm_cnt + 1;
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (!rst && i_push) begin
            if (arm_cnt != arm_seen) begin
                arm_seen = arm_cnt;
                checks++;
                if (cyc != lat_due) begin
                    errors++;
                    $display("[ERROR] %0t first push at cycle %0d, expected cycle %0d",
                             $time, cyc, lat_due);
                end
            end
            if (exp_q.size() == 0) begin
                errors++;
                $display("[ERROR] %0t push of 0x%02h with no byte expected", $time, i_data);
            end else begin
                expected = exp_q.pop_front();
                checks++;
                if (i_data !== expected) begin
                    errors++;
                    $display("[ERROR] %0t expected 0x%02h, got 0x%02h",
                             $time, expected, i_data);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/conv_stim.txt
# record as 16 hex digits, then the expected text with | for each newline
# a record with no text must produce no push
5123456780000000 W:TIME=12:34:56:78|
607B400000000000 SR04:dist=123.4cm|
72D0617320000000 DHT:|rh=45.06%|t=23.50C|
0123456789ABCDEF
523595999ABCDEF1 W:TIME=23:59:59:99|
64D270123456789A SR04:dist=234.7cm|
1000000000000000
7636300000000000 DHT:|rh=99.99%|t=00.00C|
6005000000000000 SR04:dist=005.0cm|
4FFFFFFFFFFFFFFF
63E7900000000000 SR04:dist=999.9cm|
8123456780000000
70A01095AFFFFFFF DHT:|rh=10.01%|t=09.90C|
6FFF500000000000 SR04:dist=095.5cm|
F000000000000000
5000000000000000 W:TIME=00:00:00:00|
67D0100000000000 SR04:dist=000.1cm|

// File: testbench/tb_data_convert.sv
`timescale 1ns/10ps
`default_nettype none

module tb_data_convert;

    import conv_pkg::*;

    localparam rec_t INTRUDER    = 64'h5999999990000000;  // time record sent mid-message
    localparam int   CYC_PER_RUN = 40;

    logic  clk    = 1'b0;
    logic  rst;
    logic  i_start;
    rec_t  i_data;
    logic  i_full = 1'b0;
    logic  o_push;
    char_t o_data;

    logic        bp_en;        // random back-pressure on
    bit          loaded = 1'b0;
    int          wd_limit = 0;
    int unsigned tb_errors = 0;
    rec_t        recs[$];
    string       texts[$];

    data_convert i_data_convert (
        .clk     (clk),
        .rst     (rst),
        .i_start (i_start),
        .i_data  (i_data),
        .i_full  (i_full),
        .o_push  (o_push),
        .o_data  (o_data)
    );

    conv_checker i_checker (
        .clk    (clk),
        .rst    (rst),
        .i_push (o_push),
        .i_data (o_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        i_full <= bp_en && ($urandom % 3 == 0);  // about one cycle in three
    end

    // line: 16 hex digits, then the text
    task automatic load_stim(output bit ok);
        int    fd;
        int    i;
        int    hi;
        int    lo;
        string line;
        string txt;
        ok = 1'b0;
        fd = $fopen("testbench/conv_stim.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 16 || line[0] == "#") begin
                continue;
            end
            hi  = line.substr(0, 7).atohex();
            lo  = line.substr(8, 15).atohex();
            txt = "";
            for (i = 16; i < line.len(); i++) begin
                if (line[i] != " " && line[i] != "\t" && line[i] != "\n" && line[i] != "\r") begin
                    txt = {txt, line.substr(i, i)};
                end
            end
            recs.push_back({hi, lo});
            texts.push_back(txt);
        end
        $fclose(fd);
        ok = (recs.size() > 0);
    endtask

    task automatic run_record(input rec_t rec, input string txt, input bit check_lat);
        @(negedge clk);
        i_checker.add_expected(txt);
        if (check_lat && txt.len() > 0) begin
            i_checker.arm_latency();
        end
        @(posedge clk);
        i_start <= 1'b1;
        i_data  <= rec;
        @(posedge clk);
        i_start <= 1'b0;
        if (txt.len() == 0) begin
            repeat (6) @(posedge clk);
        end else begin
            repeat (4) @(posedge clk);
            i_start <= 1'b1;  // busy, must be ignored
            i_data  <= INTRUDER;
            @(posedge clk);
            i_start <= 1'b0;
            @(negedge clk);
            while (i_checker.pending() != 0) begin
                @(negedge clk);
            end
            repeat (2) @(posedge clk);
        end
    endtask

    initial begin : watchdog
        wait (loaded);
        repeat (wd_limit) @(posedge clk);
        $display("timeout: messages still incomplete after %0d cycles", wd_limit);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        bit          ok;
        int          round;
        int          i;
        int unsigned total;
        rst     = 1'b1;
        i_start = 1'b0;
        i_data  = '0;
        bp_en   = 1'b0;
        void'($urandom(32'he30a7bc6));
        load_stim(ok);
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        if (!ok) begin
            $display("could not read any record from testbench/conv_stim.txt");
            tb_errors++;
        end else begin
            wd_limit = CYC_PER_RUN * 2 * recs.size() + 100;
            loaded   = 1'b1;
            repeat (2) @(posedge clk);
            // first round checks latency, second adds back-pressure
            for (round = 0; round < 2; round++) begin
                bp_en <= (round == 1);
                for (i = 0; i < recs.size(); i++) begin
                    run_record(recs[i], texts[i], round == 0);
                end
            end
            bp_en <= 1'b0;
            repeat (10) @(posedge clk);  // catch stray pushes
        end
        if (i_checker.pending() != 0) begin
            $display("%0d expected bytes never arrived", i_checker.pending());
            tb_errors++;
        end
        total = tb_errors + i_checker.errors + i_data_convert.i_asserts.fail_cnt;
        $display("checks=%0d errors=%0d", i_checker.checks, total);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/conv_pkg.sv
`default_nettype none

package conv_pkg;

    // field widths
    typedef logic [63:0] rec_t;   // one event record
    typedef logic [7:0]  char_t;  // ascii character
    typedef logic [3:0]  bcd_t;   // one decimal digit
    typedef logic [4:0]  idx_t;   // char position in a message

    // event code in bits 63..60 of the record
    typedef enum logic [3:0] {
        EVT_W_TIME = 4'd5,  // wall-clock time
        EVT_SR04   = 4'd6,  // ultrasonic distance
        EVT_DHT11  = 4'd7   // humidity and temperature
    } evt_e;

    // controller states
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_CAL  = 2'd1,
        ST_SEND = 2'd2
    } state_e;

    // ascii constants
    localparam char_t ASCII_ZERO = 8'd48;  // '0'
    localparam char_t ASCII_NL   = 8'd10;  // line feed
    localparam char_t ASCII_DOT  = 8'd46;  // '.'

endpackage

`default_nettype wire

// File: verilog/data_convert.sv
`timescale 1ns/10ps
`default_nettype none

module data_convert (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_start,
    input  conv_pkg::rec_t   i_data,
    input  logic             i_full,
    output logic             o_push,
    output conv_pkg::char_t  o_data
);

    import conv_pkg::*;

    logic        load;
    logic        calc;
    idx_t        idx;
    char_t       chr;
    logic        last;
    logic        known;
    evt_e        evt;
    logic [31:0] time_bcd;
    logic [15:0] dist_bcd;
    logic [15:0] hum_bcd;
    logic [15:0] temp_bcd;

    msg_ctrl u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .i_start (i_start),
        .i_full  (i_full),
        .i_char  (chr),
        .i_last  (last),
        .i_known (known),
        .o_load  (load),
        .o_calc  (calc),
        .o_idx   (idx),
        .o_push  (o_push),
        .o_data  (o_data)
    );

    sensor_bcd u_bcd (
        .clk    (clk),
        .rst    (rst),
        .i_load (load),
        .i_calc (calc),
        .i_data (i_data),
        .o_evt  (evt),
        .o_time (time_bcd),
        .o_dist (dist_bcd),
        .o_hum  (hum_bcd),
        .o_temp (temp_bcd)
    );

    msg_format u_fmt (
        .i_evt   (evt),
        .i_idx   (idx),
        .i_time  (time_bcd),
        .i_dist  (dist_bcd),
        .i_hum   (hum_bcd),
        .i_temp  (temp_bcd),
        .o_char  (chr),
        .o_last  (last),
        .o_known (known)
    );

endmodule

`default_nettype wire

// File: verilog/msg_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module msg_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_start,
    input  logic             i_full,
    input  conv_pkg::char_t  i_char,
    input  logic             i_last,
    input  logic             i_known,
    output logic             o_load,
    output logic             o_calc,
    output conv_pkg::idx_t   o_idx,
    output logic             o_push,
    output conv_pkg::char_t  o_data
);

    import conv_pkg::*;

    state_e state;

    assign o_load = (state == ST_IDLE) && i_start;  // start ignored elsewhere
    assign o_calc = (state == ST_CAL);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= ST_IDLE;
            o_idx  <= '0;
            o_push <= 1'b0;
            o_data <= '0;
        end else begin
            o_push <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        state <= ST_CAL;
                        o_idx <= '0;
                    end
                end
                ST_CAL: begin
                    if (i_known) begin
                        state <= ST_SEND;
                    end else begin
                        state <= ST_IDLE;  // drop unknown record
                    end
                end
                ST_SEND: begin
                    if (!i_full) begin
                        o_push <= 1'b1;
                        o_data <= i_char;
                        o_idx  <= idx_t'(o_idx + 1'b1);
                        if (i_last) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/msg_format.sv
`timescale 1ns/10ps
`default_nettype none

module msg_format (
    input  conv_pkg::evt_e   i_evt,
    input  conv_pkg::idx_t   i_idx,
    input  logic [31:0]      i_time,
    input  logic [15:0]      i_dist,
    input  logic [15:0]      i_hum,
    input  logic [15:0]      i_temp,
    output conv_pkg::char_t  o_char,
    output logic             o_last,
    output logic             o_known
);

    import conv_pkg::*;

    function automatic char_t dig(input bcd_t d);
        return ASCII_ZERO + char_t'(d);
    endfunction

    always_comb begin
        o_char  = 8'h00;
        o_last  = 1'b0;
        o_known = 1'b1;
        case (i_evt)
            EVT_W_TIME: begin  // W:TIME=HH:MM:SS:CC
                case (i_idx)
                    5'd0:    o_char = "W";
                    5'd1:    o_char = ":";
                    5'd2:    o_char = "T";
                    5'd3:    o_char = "I";
                    5'd4:    o_char = "M";
                    5'd5:    o_char = "E";
                    5'd6:    o_char = "=";
                    5'd7:    o_char = dig(i_time[31:28]);
                    5'd8:    o_char = dig(i_time[27:24]);
                    5'd9:    o_char = ":";
                    5'd10:   o_char = dig(i_time[23:20]);
                    5'd11:   o_char = dig(i_time[19:16]);
                    5'd12:   o_char = ":";
                    5'd13:   o_char = dig(i_time[15:12]);
                    5'd14:   o_char = dig(i_time[11:8]);
                    5'd15:   o_char = ":";
                    5'd16:   o_char = dig(i_time[7:4]);
                    5'd17:   o_char = dig(i_time[3:0]);
                    5'd18:   o_char = ASCII_NL;
                    default: o_char = 8'h00;
                endcase
                o_last = (i_idx == 5'd18);
            end
            EVT_SR04: begin  // SR04:dist=DDD.dcm
                case (i_idx)
                    5'd0:    o_char = "S";
                    5'd1:    o_char = "R";
                    5'd2:    o_char = "0";
                    5'd3:    o_char = "4";
                    5'd4:    o_char = ":";
                    5'd5:    o_char = "d";
                    5'd6:    o_char = "i";
                    5'd7:    o_char = "s";
                    5'd8:    o_char = "t";
                    5'd9:    o_char = "=";
                    5'd10:   o_char = dig(i_dist[15:12]);  // hundreds
                    5'd11:   o_char = dig(i_dist[11:8]);
                    5'd12:   o_char = dig(i_dist[7:4]);
                    5'd13:   o_char = ASCII_DOT;
                    5'd14:   o_char = dig(i_dist[3:0]);    // tenths
                    5'd15:   o_char = "c";
                    5'd16:   o_char = "m";
                    5'd17:   o_char = ASCII_NL;
                    default: o_char = 8'h00;
                endcase
                o_last = (i_idx == 5'd17);
            end
            EVT_DHT11: begin  // three lines
                case (i_idx)
                    5'd0:    o_char = "D";
                    5'd1:    o_char = "H";
                    5'd2:    o_char = "T";
                    5'd3:    o_char = ":";
                    5'd4:    o_char = ASCII_NL;
                    5'd5:    o_char = "r";
                    5'd6:    o_char = "h";
                    5'd7:    o_char = "=";
                    5'd8:    o_char = dig(i_hum[15:12]);
                    5'd9:    o_char = dig(i_hum[11:8]);
                    5'd10:   o_char = ASCII_DOT;
                    5'd11:   o_char = dig(i_hum[7:4]);
                    5'd12:   o_char = dig(i_hum[3:0]);
                    5'd13:   o_char = "%";
                    5'd14:   o_char = ASCII_NL;
                    5'd15:   o_char = "t";
                    5'd16:   o_char = "=";
                    5'd17:   o_char = dig(i_temp[15:12]);
                    5'd18:   o_char = dig(i_temp[11:8]);
                    5'd19:   o_char = ASCII_DOT;
                    5'd20:   o_char = dig(i_temp[7:4]);
                    5'd21:   o_char = dig(i_temp[3:0]);
                    5'd22:   o_char = "C";
                    5'd23:   o_char = ASCII_NL;
                    default: o_char = 8'h00;
                endcase
                o_last = (i_idx == 5'd23);
            end
            default: begin
                o_known = 1'b0;  // stopwatch and unused codes
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/sensor_bcd.sv
`timescale 1ns/10ps
`default_nettype none

module sensor_bcd (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_load,
    input  logic             i_calc,
    input  conv_pkg::rec_t   i_data,
    output conv_pkg::evt_e   o_evt,
    output logic [31:0]      o_time,
    output logic [15:0]      o_dist,
    output logic [15:0]      o_hum,
    output logic [15:0]      o_temp
);

    import conv_pkg::*;

    logic [31:0] time_q;      // bcd already
    logic [11:0] dist_int;    // centimeters
    bcd_t        dist_frac;   // tenths
    logic [7:0]  hum_int;
    logic [7:0]  hum_dec;
    logic [7:0]  temp_int;
    logic [7:0]  temp_dec;

    logic [11:0] dist_m1000;
    logic [11:0] dist_m100;
    logic [11:0] dist_hund;
    logic [11:0] dist_tens;
    logic [11:0] dist_ones;

    // byte up to 99 -> {tens, ones}
    function automatic logic [7:0] two_digits(input logic [7:0] val);
        logic [7:0] tens;
        logic [7:0] ones;
        tens = val / 8'd10;
        ones = val % 8'd10;
        return {tens[3:0], ones[3:0]};
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_evt <= evt_e'(4'd0);
        end else if (i_load) begin
            o_evt <= evt_e'(i_data[63:60]);
        end
    end

    // the three layouts overlap in 59..28
    always_ff @(posedge clk) begin
        if (i_load) begin
            time_q    <= i_data[59:28];
            dist_int  <= i_data[59:48];
            dist_frac <= i_data[47:44];
            hum_int   <= i_data[59:52];
            hum_dec   <= i_data[51:44];
            temp_int  <= i_data[43:36];
            temp_dec  <= i_data[35:28];
        end
    end

    always_comb begin
        dist_m1000 = dist_int % 12'd1000;  // values above 999 wrap
        dist_m100  = dist_int % 12'd100;
        dist_hund  = dist_m1000 / 12'd100;
        dist_tens  = dist_m100 / 12'd10;
        dist_ones  = dist_int % 12'd10;
    end

    always_ff @(posedge clk) begin
        if (i_calc) begin
            o_dist <= {dist_hund[3:0], dist_tens[3:0], dist_ones[3:0], dist_frac};
            o_hum  <= {two_digits(hum_int), two_digits(hum_dec)};
            o_temp <= {two_digits(temp_int), two_digits(temp_dec)};
        end
    end

    assign o_time = time_q;

endmodule

`default_nettype wire
